//--- frontend_top.f
+incdir+common
common/fe_pkg.sv
src/fetch/pc_gen.sv
src/fetch/axi_fetch_master.sv
src/fetch/if2_predecoder.sv
src/fetch_queue.sv
src/frontend_top.sv
dv/imem_model.sv
dv/frontend_tb.sv

//--- dv/frontend_tb.sv
`default_nettype none

`include "fe_cfg.svh"

module frontend_tb;

    localparam int WORDS = 256;

    logic                 clk;
    logic                 rst_n;
    fe_pkg::axi_ar_t      ar;
    logic                 arvalid;
    logic                 arready;
    fe_pkg::axi_r_t       r;
    logic                 rvalid;
    logic                 rready;
    fe_pkg::fe_redirect_t redirect;
    logic                 deq_valid;
    logic                 deq_ready;
    fe_pkg::fe_inst_t     deq_inst;
    logic [2:0]           imem_rand;

    logic [31:0] prog [WORDS];
    logic [31:0] lfsr_state;
    logic [31:0] exp_pc;
    logic [31:0] redirect_pc;
    logic        redirect_arm;
    logic        redirect_on_ar;
    logic        stall_mode;
    logic        timed_out;
    int          delivered;
    int          errors;
    int          proto_errors;

    frontend_top i_frontend_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .redirect  (redirect),
        .deq_valid (deq_valid),
        .deq_ready (deq_ready),
        .deq_inst  (deq_inst)
    );

    imem_model #(
        .WORDS (WORDS)
    ) i_imem_model (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .rnd     (imem_rand)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    ////////////////////
    // Handshake rules
    ////////////////////

    // A stalled decode word holds until taken, unless a redirect flushes it
    assert property (@(posedge clk) disable iff (!rst_n)
        (deq_valid && !deq_ready && !redirect.valid) |=> (deq_valid && $stable(deq_inst)))
    else begin
        proto_errors++;
        $display("deq_inst changed or dropped at t=%0t while decode was stalled", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid && !arready) |=> (arvalid && $stable(ar)))
    else begin
        proto_errors++;
        $display("AR request changed or dropped at t=%0t before arready", $time);
    end

    ////////////////////
    // Random bits
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    ////////////////////
    // Program image
    ////////////////////

    task automatic place16(input int slot, input logic [5:0] op, input int offs);
        prog[slot] = {op, offs[15:0], prog[slot][9:0]};
    endtask

    // offs26 low half sits in 25:10, high part in 9:0
    task automatic place26(input int slot, input logic [5:0] op, input int offs);
        prog[slot] = {op, offs[15:0], offs[25:16]};
    endtask

    task automatic load_program();
        logic [31:0] w;
        for (int i = 0; i < WORDS; i++) begin
            take_bits(32, w);
            // Fill words stay off the branch opcodes
            if (w[31:26] >= 6'h13 && w[31:26] <= 6'h1b) begin
                w[31] = 1'b1;
            end
            prog[i] = w;
        end
        place16(10, 6'h13, 3);
        place16(12, 6'h16, 20);
        place26(14, 6'h15, 26);
        place26(40, 6'h14, 16);
        place16(60, 6'h1a, -8);
        place16(52, 6'h18, -2);
        place26(50, 6'h14, 50);
        place16(200, 6'h1b, 3);
        place16(202, 6'h17, 5);
        place16(203, 6'h19, 4);
        // Wrap to the first word, a negative offs26
        place26(255, 6'h14, -255);
        for (int i = 0; i < WORDS; i++) begin
            i_imem_model.mem[i] = prog[i];
        end
    endtask

    ////////////////////
    // Reference walk
    ////////////////////

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - `FE_RESET_PC;
        if (offs < 32'(WORDS * 4)) begin
            word_at = prog[offs[$clog2(WORDS)+1:2]];
        end else begin
            word_at = ~addr;
        end
    endfunction

    function automatic fe_pkg::fe_inst_t expect_inst(input logic [31:0] pc);
        fe_pkg::fe_inst_t e;
        logic [31:0]      w;
        logic [31:0]      offs;
        w = word_at(pc);
        e.pc = pc;
        e.instr = w;
        if (w[31:26] >= 6'h16 && w[31:26] <= 6'h1b) begin
            e.br_type = fe_pkg::BR_COND;
        end else if (w[31:27] == 5'b01010) begin
            e.br_type = fe_pkg::BR_DIRECT;
        end else if (w[31:26] == 6'h13) begin
            e.br_type = fe_pkg::BR_JIRL;
        end else begin
            e.br_type = fe_pkg::BR_NONE;
        end
        if (e.br_type == fe_pkg::BR_DIRECT) begin
            offs = {{6{w[9]}}, w[9:0], w[25:10]} << 2;
        end else if (e.br_type == fe_pkg::BR_NONE) begin
            offs = 32'd0;
        end else begin
            offs = {{16{w[25]}}, w[25:10]} << 2;
        end
        e.pred_target = pc + offs;
        // Only backward conditional branches count as taken
        e.pred_taken = (e.br_type == fe_pkg::BR_DIRECT)
                    || ((e.br_type == fe_pkg::BR_COND) && offs[31]);
        expect_inst = e;
    endfunction

    task automatic check_field(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        assert (got == want) else begin
            errors++;
            $display("error t=%0t %s expected %h actual %h", $time, name, want, got);
        end
    endtask

    task automatic check_deq();
        fe_pkg::fe_inst_t want;
        want = expect_inst(exp_pc);
        check_field("deq_inst.pc", want.pc, deq_inst.pc);
        check_field("deq_inst.instr", want.instr, deq_inst.instr);
        check_field("deq_inst.br_type", 32'(want.br_type), 32'(deq_inst.br_type));
        check_field("deq_inst.pred_taken", 32'(want.pred_taken), 32'(deq_inst.pred_taken));
        check_field("deq_inst.pred_target", want.pred_target, deq_inst.pred_target);
        delivered++;
        exp_pc = want.pred_taken ? want.pred_target : want.pc + 32'd4;
    endtask

    ////////////////////
    // Clocked stimulus
    ////////////////////

    // Samples the values before the edge, then drives the next cycle
    task automatic step_cycle();
        logic [31:0] rb;
        logic        in_flight;
        @(posedge clk);
        if (deq_valid && deq_ready) begin
            check_deq();
        end
        if (redirect.valid) begin
            exp_pc = redirect.pc;
        end
        take_bits(7, rb);
        // Either an AR still waiting for arready or an R beat still pending
        in_flight = redirect_on_ar ? (arvalid && !arready) : (rready && !rvalid);
        if (redirect_arm && deq_valid && !deq_ready && (i_frontend_top.fq_free != 0)
                && in_flight) begin
            redirect     <= '{valid: 1'b1, pc: redirect_pc};
            deq_ready    <= 1'b0;
            redirect_arm = 1'b0;
            // Keep the AR waiting across the redirect edge
            imem_rand    <= redirect_on_ar ? {rb[2:1], 1'b0} : rb[2:0];
        end else begin
            redirect  <= '0;
            deq_ready <= stall_mode ? (rb[6:3] == 4'd0) : (rb[4:3] != 2'd0);
            imem_rand <= rb[2:0];
        end
    endtask

    task automatic run_until_delivered(input int count, input int limit);
        int target;
        int waited;
        target = delivered + count;
        waited = 0;
        while (!timed_out && delivered < target) begin
            if (waited == limit) begin
                timed_out = 1'b1;
                $display("timeout: decode took %0d of %0d instructions in %0d cycles",
                         count - (target - delivered), count, limit);
            end else begin
                step_cycle();
                waited++;
            end
        end
    endtask

    task automatic redirect_mid_fetch(input logic [31:0] pc, input logic on_ar,
                                      input int limit);
        int waited;
        redirect_pc = pc;
        redirect_arm = 1'b1;
        redirect_on_ar = on_ar;
        stall_mode = 1'b1;
        waited = 0;
        while (!timed_out && redirect_arm) begin
            if (waited == limit) begin
                timed_out = 1'b1;
                $display("timeout: no cycle with a partly full queue and a read in flight");
            end else begin
                step_cycle();
                waited++;
            end
        end
        stall_mode = 1'b0;
        redirect_on_ar = 1'b0;
    endtask

    initial begin
        rst_n = 1'b0;
        deq_ready = 1'b0;
        redirect = '0;
        imem_rand = '0;
        redirect_pc = '0;
        redirect_arm = 1'b0;
        redirect_on_ar = 1'b0;
        stall_mode = 1'b0;
        timed_out = 1'b0;
        delivered = 0;
        errors = 0;
        proto_errors = 0;
        lfsr_state = 32'haeaa;
        exp_pc = `FE_RESET_PC;
        load_program();
        repeat (3) step_cycle();
        rst_n <= 1'b1;
        // Full program loop, all branch classes and the wrap
        run_until_delivered(400, 4000);
        // Long decode stalls
        stall_mode = 1'b1;
        run_until_delivered(60, 4000);
        stall_mode = 1'b0;
        redirect_mid_fetch(`FE_RESET_PC + 32'd480, 1'b0, 500);
        run_until_delivered(40, 1000);
        // Redirect while the AR is still waiting for arready
        redirect_mid_fetch(`FE_RESET_PC + 32'd12, 1'b1, 500);
        run_until_delivered(40, 1000);
        redirect_mid_fetch(`FE_RESET_PC + 32'd228, 1'b0, 500);
        run_until_delivered(40, 1000);
        $display("delivered %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 delivered, errors, proto_errors, timed_out);
        if (!timed_out && errors == 0 && proto_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/imem_model.sv
`default_nettype none

`include "fe_cfg.svh"

module imem_model #(
    parameter int WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  fe_pkg::axi_ar_t ar,
    input  logic            arvalid,
    output logic            arready,
    output fe_pkg::axi_r_t  r,
    output logic            rvalid,
    input  logic            rready,
    // Random bits from the testbench LFSR, fresh each cycle
    input  logic [2:0]      rnd
);

    logic [31:0] mem [WORDS];
    logic        busy;
    logic [1:0]  delay;
    logic [31:0] addr_q;

    // Outside the array the word is the inverted address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - `FE_RESET_PC;
        if (offs < 32'(WORDS * 4)) begin
            read_word = mem[offs[$clog2(WORDS)+1:2]];
        end else begin
            read_word = ~addr;
        end
    endfunction

    ////////////////////
    // One read at a time
    ////////////////////

    assign arready = !busy && rnd[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rvalid <= 1'b0;
            delay  <= 2'd0;
            r      <= '0;
        end else if (arvalid && arready) begin
            busy   <= 1'b1;
            addr_q <= ar.araddr;
            delay  <= rnd[2:1];
        end else if (busy && !rvalid) begin
            // Extra wait of 0 to 3 cycles before the beat
            if (delay == 2'd0) begin
                rvalid  <= 1'b1;
                r.rdata <= read_word(addr_q);
                r.rresp <= 2'b00;
            end else begin
                delay <= delay - 2'd1;
            end
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
            busy   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/frontend_top.sv
`default_nettype none

`include "fe_cfg.svh"

module frontend_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // AXI4-Lite read port
    output fe_pkg::axi_ar_t      ar,
    output logic                 arvalid,
    input  logic                 arready,
    input  fe_pkg::axi_r_t       r,
    input  logic                 rvalid,
    output logic                 rready,
    // Backend redirect
    input  fe_pkg::fe_redirect_t redirect,
    // Decode side
    output logic                 deq_valid,
    input  logic                 deq_ready,
    output fe_pkg::fe_inst_t     deq_inst
);

    logic [31:0]                          fetch_pc;
    logic                                 fetch_done;
    logic [31:0]                          fetch_pc_out;
    logic [31:0]                          fetch_word;
    logic [$clog2(`FE_FQ_DEPTH+1)-1:0]    fq_free;
    fe_pkg::fe_inst_t                     pd_inst;

    ////////////////////
    // IF1: PC and AXI fetch
    ////////////////////

    pc_gen i_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .fetch_done  (fetch_done),
        .pred_taken  (pd_inst.pred_taken),
        .pred_target (pd_inst.pred_target),
        .fetch_pc    (fetch_pc)
    );

    axi_fetch_master i_axi_fetch_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_pc     (fetch_pc),
        .flush        (redirect.valid),
        .fq_free      (fq_free),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .fetch_done   (fetch_done),
        .fetch_pc_out (fetch_pc_out),
        .fetch_word   (fetch_word)
    );

    ////////////////////
    // IF2: predecode and queue
    ////////////////////

    if2_predecoder i_if2_predecoder (
        .pc    (fetch_pc_out),
        .instr (fetch_word),
        .inst  (pd_inst)
    );

    fetch_queue #(
        .item_t (fe_pkg::fe_inst_t),
        .DEPTH  (`FE_FQ_DEPTH)
    ) i_fetch_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect.valid),
        .push      (fetch_done),
        .push_data (pd_inst),
        .free      (fq_free),
        .pop_valid (deq_valid),
        .pop_ready (deq_ready),
        .pop_data  (deq_inst)
    );

endmodule

`default_nettype wire

//--- src/fetch_queue.sv
`default_nettype none

module fetch_queue #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         push,
    input  item_t                        push_data,
    output logic [$clog2(DEPTH+1)-1:0]   free,
    output logic                         pop_valid,
    input  logic                         pop_ready,
    output item_t                        pop_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH+1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == CNT_W'(DEPTH));
    assign pop_valid = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop_valid && pop_ready;

    ////////////////////
    // Pointers and count
    ////////////////////

    // Flush wins over a push or pop in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];
    assign free     = CNT_W'(DEPTH) - count;

endmodule

`default_nettype wire

//--- src/fetch/if2_predecoder.sv
`default_nettype none

module if2_predecoder (
    input  logic [31:0]      pc,
    input  logic [31:0]      instr,
    output fe_pkg::fe_inst_t inst
);

    logic [5:0]        opcode;
    fe_pkg::br_type_e  br_type;
    logic [31:0]       offs16;
    logic [31:0]       offs26;
    logic [31:0]       offset;
    logic              taken;

    assign opcode = instr[31:26];

    ////////////////////
    // Branch class
    ////////////////////

    always_comb begin
        case (opcode)
            6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: br_type = fe_pkg::BR_COND;
            6'h14, 6'h15:                             br_type = fe_pkg::BR_DIRECT;
            6'h13:                                    br_type = fe_pkg::BR_JIRL;
            default:                                  br_type = fe_pkg::BR_NONE;
        endcase
    end

    ////////////////////
    // Target
    ////////////////////

    // 16-bit field for conditional branches and jirl
    assign offs16 = {{14{instr[25]}}, instr[25:10], 2'b00};
    // b and bl split their 26-bit offset, high part in 9:0
    assign offs26 = {{4{instr[9]}}, instr[9:0], instr[25:10], 2'b00};

    always_comb begin
        case (br_type)
            fe_pkg::BR_COND,
            fe_pkg::BR_JIRL:   offset = offs16;
            fe_pkg::BR_DIRECT: offset = offs26;
            default:           offset = 32'd0;
        endcase
    end

    // Backward conditional taken, forward not; jirl needs rj
    always_comb begin
        case (br_type)
            fe_pkg::BR_DIRECT: taken = 1'b1;
            fe_pkg::BR_COND:   taken = instr[25];
            default:           taken = 1'b0;
        endcase
    end

    assign inst.pc          = pc;
    assign inst.instr       = instr;
    assign inst.br_type     = br_type;
    assign inst.pred_taken  = taken;
    assign inst.pred_target = pc + offset;

endmodule

`default_nettype wire

//--- src/fetch/axi_fetch_master.sv
`default_nettype none

module axi_fetch_master (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [31:0]     fetch_pc,
    input  logic            flush,
    input  logic [2:0]      fq_free,
    output fe_pkg::axi_ar_t ar,
    output logic            arvalid,
    input  logic            arready,
    input  fe_pkg::axi_r_t  r,
    input  logic            rvalid,
    output logic            rready,
    output logic            fetch_done,
    output logic [31:0]     fetch_pc_out,
    output logic [31:0]     fetch_word
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } state_e;

    state_e      state;
    state_e      state_nxt;
    logic        stale;
    logic [31:0] issue_pc;
    logic        inflight;
    logic        room;
    logic        ar_fire;
    logic        r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    ////////////////////
    // Queue room check
    ////////////////////

    // A live fetch already owns one free entry; a stale one lands nowhere
    assign inflight = (state != S_IDLE) && !stale;
    assign room     = ({2'b00, inflight} < fq_free);

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (room) begin
                    state_nxt = S_ADDR;
                end
            end
            S_ADDR: begin
                if (ar_fire) begin
                    state_nxt = S_DATA;
                end
            end
            S_DATA: begin
                // Back to back when the queue can take another word
                if (r_fire) begin
                    state_nxt = room ? S_ADDR : S_IDLE;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            stale <= 1'b0;
        end else begin
            state <= state_nxt;
            // Flush while a transaction is open marks its beat as dead
            if (r_fire) begin
                stale <= 1'b0;
            end else if (flush && (state != S_IDLE)) begin
                stale <= 1'b1;
            end
        end
    end

    // Track the PC until the open AR goes stale, then freeze it
    always_ff @(posedge clk) begin
        if ((state == S_ADDR) && !stale) begin
            issue_pc <= fetch_pc;
        end
    end

    ////////////////////
    // Channel outputs
    ////////////////////

    assign arvalid   = (state == S_ADDR);
    assign ar.araddr = stale ? issue_pc : fetch_pc;
    // Unprivileged instruction access
    assign ar.arprot = 3'b100;
    assign rready    = (state == S_DATA);

    assign fetch_done   = r_fire && !stale;
    assign fetch_pc_out = issue_pc;
    assign fetch_word   = r.rdata;

endmodule

`default_nettype wire

//--- src/fetch/pc_gen.sv
`default_nettype none

`include "fe_cfg.svh"

module pc_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fe_pkg::fe_redirect_t redirect,
    input  logic                 fetch_done,
    input  logic                 pred_taken,
    input  logic [31:0]          pred_target,
    output logic [31:0]          fetch_pc
);

    logic [31:0] pc_q;
    logic [31:0] pc_seq;
    logic [31:0] pc_nxt;

    ////////////////////
    // Next PC select
    ////////////////////

    // Fall-through address of the word just returned
    assign pc_seq = pc_q + 32'd4;

    // Redirect beats a prediction from the same cycle
    always_comb begin
        pc_nxt = pc_q;
        if (redirect.valid) begin
            pc_nxt = redirect.pc;
        end else if (fetch_done) begin
            if (pred_taken) begin
                pc_nxt = pred_target;
            end else begin
                pc_nxt = pc_seq;
            end
        end
    end

    ////////////////////
    // PC register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= `FE_RESET_PC;
        end else begin
            pc_q <= pc_nxt;
        end
    end

    // Holds while a fetch is open, moves only on done or redirect
    assign fetch_pc = pc_q;

endmodule

`default_nettype wire

//--- common/fe_pkg.sv
`default_nettype none

`include "fe_cfg.svh"

package fe_pkg;

    ////////////////////
    // Branch classes
    ////////////////////

    // Static class of a fetched word, from opcode bits 31:26
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        // beq, bne, blt, bge, bltu, bgeu
        BR_COND   = 2'd1,
        // b, bl
        BR_DIRECT = 2'd2,
        // Register-indirect jump
        BR_JIRL   = 2'd3
    } br_type_e;

    ////////////////////
    // AXI4-Lite read channels
    ////////////////////

    // AR payload
    typedef struct packed {
        logic [`FE_ADDR_W-1:0] araddr;
        logic [2:0]            arprot;
    } axi_ar_t;

    // R payload, rresp is carried but not checked
    typedef struct packed {
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axi_r_t;

    ////////////////////
    // Front end payloads
    ////////////////////

    // One pre-decoded instruction on its way to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        br_type_e    br_type;
        logic        pred_taken;
        logic [31:0] pred_target;
    } fe_inst_t;

    // Backend redirect, valid for one cycle
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fe_redirect_t;

endpackage

`default_nettype wire

//--- common/fe_cfg.svh
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

////////////////////
// Fetch front end configuration
////////////////////

// First fetch address after reset
`define FE_RESET_PC 32'h1c00_0000

// Entries in the fetch queue
`define FE_FQ_DEPTH 4

// AXI read address width
`define FE_ADDR_W 32

`endif
